//--- design/div_pkg.sv
package div_pkg;

    // Defaults for the top-level parameters. The structs below are sized with them.
    localparam int DATA_WIDTH  = 32;
    localparam int LANE_COUNT  = 4;
    localparam int QUEUE_DEPTH = 8;
    localparam int TAG_WIDTH   = 8;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] dividend;
        logic [DATA_WIDTH-1:0] divisor;
    } div_job_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] quotient;
        logic [DATA_WIDTH-1:0] remainder;
    } div_result_t;

    // Word addresses on the Wishbone bus.
    localparam logic [2:0] ADDR_DIVIDEND  = 3'd0;
    localparam logic [2:0] ADDR_DIVISOR   = 3'd1;
    localparam logic [2:0] ADDR_STATUS    = 3'd2;
    localparam logic [2:0] ADDR_TAG       = 3'd3;
    localparam logic [2:0] ADDR_QUOTIENT  = 3'd4;
    localparam logic [2:0] ADDR_REMAINDER = 3'd5;

endpackage

//--- design/lane_bus_if.sv
`timescale 1ns/1ps

interface lane_bus_if
    import div_pkg::*;
#(
    parameter int LANE_COUNT = div_pkg::LANE_COUNT
);

    logic [LANE_COUNT-1:0] issue_valid;
    logic [LANE_COUNT-1:0] issue_ready;
    div_job_t              issue_job [LANE_COUNT];

    logic [LANE_COUNT-1:0] done_valid;
    logic [LANE_COUNT-1:0] done_ready;
    div_result_t           done_result [LANE_COUNT];

    modport dispatcher (output issue_valid, output issue_job, input issue_ready);

    modport collector (input done_valid, input done_result, output done_ready);

endinterface

//--- design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     full,
    output logic     empty,
    output payload_t head
);

    localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    payload_t               mem [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    function automatic logic [PTR_WIDTH-1:0] advance(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_WIDTH'(1);
    endfunction

    assign full    = (count == COUNT_WIDTH'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= advance(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= advance(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + COUNT_WIDTH'(1);
                2'b01:   count <= count - COUNT_WIDTH'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- design/div_lane.sv
`timescale 1ns/1ps

module div_lane
    import div_pkg::*;
#(
    parameter int DATA_WIDTH = div_pkg::DATA_WIDTH
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue_valid,
    input  div_job_t    issue_job,
    output logic        issue_ready,
    output logic        done_valid,
    input  logic        done_ready,
    output div_result_t done_result
);

    localparam int STEP_WIDTH = $clog2(DATA_WIDTH + 1);

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_ITERATE,
        LANE_HOLD
    } lane_state_t;

    lane_state_t           state;
    logic [STEP_WIDTH-1:0] step;
    logic                  last_step;

    // Partial remainder in the upper DATA_WIDTH+1 bits, quotient in the lower bits.
    logic [2*DATA_WIDTH:0] acc;
    logic [2*DATA_WIDTH:0] acc_next;
    logic [2*DATA_WIDTH:0] shifted;
    logic [DATA_WIDTH:0]   partial;
    logic                  quotient_bit;
    logic [DATA_WIDTH-1:0] divisor;
    logic [TAG_WIDTH-1:0]  tag;

    assign last_step = (step == STEP_WIDTH'(DATA_WIDTH - 1));

    // One non-restoring step. The add or subtract choice follows the sign of the
    // remainder before the shift, and the last step restores a negative remainder.
    always_comb begin
        shifted = acc << 1;
        if (acc[2*DATA_WIDTH]) begin
            partial = shifted[2*DATA_WIDTH:DATA_WIDTH] + {1'b0, divisor};
        end else begin
            partial = shifted[2*DATA_WIDTH:DATA_WIDTH] - {1'b0, divisor};
        end
        quotient_bit = ~partial[DATA_WIDTH];
        if (last_step && partial[DATA_WIDTH]) begin
            partial = partial + {1'b0, divisor};
        end
        acc_next = {partial, shifted[DATA_WIDTH-1:1], quotient_bit};
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= LANE_IDLE;
            step  <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (issue_valid) begin
                        state <= LANE_ITERATE;
                        step  <= '0;
                    end
                end
                LANE_ITERATE: begin
                    step <= step + STEP_WIDTH'(1);
                    if (last_step) begin
                        state <= LANE_HOLD;
                    end
                end
                LANE_HOLD: begin
                    if (done_ready) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == LANE_IDLE && issue_valid) begin
            acc     <= {{(DATA_WIDTH + 1){1'b0}}, issue_job.dividend};
            divisor <= issue_job.divisor;
            tag     <= issue_job.tag;
        end else if (state == LANE_ITERATE) begin
            acc <= acc_next;
        end
    end

    assign issue_ready           = (state == LANE_IDLE);
    assign done_valid            = (state == LANE_HOLD);
    assign done_result.tag       = tag;
    assign done_result.quotient  = acc[DATA_WIDTH-1:0];
    assign done_result.remainder = acc[2*DATA_WIDTH-1:DATA_WIDTH];

endmodule

//--- design/job_dispatcher.sv
`timescale 1ns/1ps

module job_dispatcher
    import div_pkg::*;
#(
    parameter int LANE_COUNT  = div_pkg::LANE_COUNT,
    parameter int QUEUE_DEPTH = div_pkg::QUEUE_DEPTH
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      job_valid,
    input  div_job_t  job,
    output logic      job_ready,
    lane_bus_if.dispatcher lanes
);

    localparam int IDX_WIDTH = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1;

    logic                 queue_full;
    logic                 queue_empty;
    div_job_t             head_job;
    logic                 issue;
    logic                 found;
    logic [IDX_WIDTH-1:0] sel;
    logic [IDX_WIDTH-1:0] rr_ptr;

    stream_fifo #(
        .payload_t (div_job_t),
        .DEPTH     (QUEUE_DEPTH)
    ) job_queue_i (
        .clock     (clock),
        .reset     (reset),
        .push      (job_valid),
        .push_data (job),
        .pop       (issue),
        .full      (queue_full),
        .empty     (queue_empty),
        .head      (head_job)
    );

    assign job_ready = !queue_full;

    // First idle lane at or after the round-robin pointer.
    always_comb begin : search
        int cand;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            cand = (int'(rr_ptr) + i) % LANE_COUNT;
            if (!found && lanes.issue_ready[cand]) begin
                found = 1'b1;
                sel   = IDX_WIDTH'(cand);
            end
        end
    end

    assign issue = found && !queue_empty;

    always_comb begin
        for (int i = 0; i < LANE_COUNT; i++) begin
            lanes.issue_valid[i] = issue && (sel == IDX_WIDTH'(i));
            lanes.issue_job[i]   = head_job;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (issue) begin
            rr_ptr <= (sel == IDX_WIDTH'(LANE_COUNT - 1)) ? '0 : sel + IDX_WIDTH'(1);
        end
    end

endmodule

//--- design/result_collector.sv
`timescale 1ns/1ps

module result_collector
    import div_pkg::*;
#(
    parameter int LANE_COUNT  = div_pkg::LANE_COUNT,
    parameter int QUEUE_DEPTH = div_pkg::QUEUE_DEPTH
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        result_pop,
    output logic        result_valid,
    output div_result_t result,
    lane_bus_if.collector lanes
);

    localparam int IDX_WIDTH = (LANE_COUNT > 1) ? $clog2(LANE_COUNT) : 1;

    logic                 queue_full;
    logic                 queue_empty;
    logic                 found;
    logic                 take;
    logic [IDX_WIDTH-1:0] sel;
    logic [IDX_WIDTH-1:0] rr_ptr;
    div_result_t          taken_result;

    // Grant goes to the first finished lane at or after the pointer.
    always_comb begin : grant
        int cand;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            cand = (int'(rr_ptr) + i) % LANE_COUNT;
            if (!found && lanes.done_valid[cand]) begin
                found = 1'b1;
                sel   = IDX_WIDTH'(cand);
            end
        end
    end

    // A full result queue leaves the result waiting in its lane.
    assign take         = found && !queue_full;
    assign taken_result = lanes.done_result[sel];

    always_comb begin
        for (int i = 0; i < LANE_COUNT; i++) begin
            lanes.done_ready[i] = take && (sel == IDX_WIDTH'(i));
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (take) begin
            rr_ptr <= (sel == IDX_WIDTH'(LANE_COUNT - 1)) ? '0 : sel + IDX_WIDTH'(1);
        end
    end

    stream_fifo #(
        .payload_t (div_result_t),
        .DEPTH     (QUEUE_DEPTH)
    ) result_queue_i (
        .clock     (clock),
        .reset     (reset),
        .push      (take),
        .push_data (taken_result),
        .pop       (result_pop),
        .full      (queue_full),
        .empty     (queue_empty),
        .head      (result)
    );

    assign result_valid = !queue_empty;

endmodule

//--- design/wb_div_regs.sv
`timescale 1ns/1ps

module wb_div_regs
    import div_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        job_ready,
    output logic        job_valid,
    output div_job_t    job,
    input  logic        result_valid,
    input  div_result_t result,
    output logic        result_pop
);

    logic                  request;
    logic                  divisor_write;
    logic                  accept;
    logic [DATA_WIDTH-1:0] dividend;
    logic [TAG_WIDTH-1:0]  next_tag;
    logic [31:0]           read_data;

    // The ack cycle itself is not a new request.
    assign request       = wb_cyc && wb_stb && !wb_ack;
    assign divisor_write = request && wb_we && (wb_adr == ADDR_DIVISOR);

    // A divisor write waits here until the job queue has room.
    assign accept = request && !(divisor_write && !job_ready);

    assign job_valid    = divisor_write;
    assign job.tag      = next_tag;
    assign job.dividend = dividend;
    assign job.divisor  = wb_dat_w[DATA_WIDTH-1:0];

    assign result_pop = request && !wb_we && (wb_adr == ADDR_REMAINDER) && result_valid;

    always_comb begin
        read_data = '0;
        case (wb_adr)
            ADDR_STATUS: begin
                read_data = {30'd0, !job_ready, result_valid};
            end
            ADDR_TAG: begin
                if (result_valid) begin
                    read_data = 32'(result.tag);
                end
            end
            ADDR_QUOTIENT: begin
                if (result_valid) begin
                    read_data = 32'(result.quotient);
                end
            end
            ADDR_REMAINDER: begin
                if (result_valid) begin
                    read_data = 32'(result.remainder);
                end
            end
            default: read_data = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack   <= 1'b0;
            next_tag <= '0;
        end else begin
            wb_ack <= accept;
            if (job_valid && job_ready) begin
                next_tag <= next_tag + TAG_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (request && wb_we && (wb_adr == ADDR_DIVIDEND)) begin
            dividend <= wb_dat_w[DATA_WIDTH-1:0];
        end
        if (accept && !wb_we) begin
            wb_dat_r <= read_data;
        end
    end

endmodule

//--- design/div_array_top.sv
`timescale 1ns/1ps

module div_array_top
    import div_pkg::*;
#(
    parameter int DATA_WIDTH  = div_pkg::DATA_WIDTH,
    parameter int LANE_COUNT  = div_pkg::LANE_COUNT,
    parameter int QUEUE_DEPTH = div_pkg::QUEUE_DEPTH
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    logic        job_valid;
    logic        job_ready;
    div_job_t    job;
    logic        result_valid;
    logic        result_pop;
    div_result_t result;

    lane_bus_if #(.LANE_COUNT(LANE_COUNT)) lane_bus ();

    wb_div_regs regs_i (
        .clock        (clock),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .job_ready    (job_ready),
        .job_valid    (job_valid),
        .job          (job),
        .result_valid (result_valid),
        .result       (result),
        .result_pop   (result_pop)
    );

    job_dispatcher #(
        .LANE_COUNT  (LANE_COUNT),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dispatcher_i (
        .clock     (clock),
        .reset     (reset),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .lanes     (lane_bus.dispatcher)
    );

    for (genvar g = 0; g < LANE_COUNT; g++) begin : gen_lane
        div_lane #(
            .DATA_WIDTH (DATA_WIDTH)
        ) lane_i (
            .clock       (clock),
            .reset       (reset),
            .issue_valid (lane_bus.issue_valid[g]),
            .issue_job   (lane_bus.issue_job[g]),
            .issue_ready (lane_bus.issue_ready[g]),
            .done_valid  (lane_bus.done_valid[g]),
            .done_ready  (lane_bus.done_ready[g]),
            .done_result (lane_bus.done_result[g])
        );
    end

    result_collector #(
        .LANE_COUNT  (LANE_COUNT),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) collector_i (
        .clock        (clock),
        .reset        (reset),
        .result_pop   (result_pop),
        .result_valid (result_valid),
        .result       (result),
        .lanes        (lane_bus.collector)
    );

endmodule

//--- test/div_array_asserts.sv
`timescale 1ns/1ps

module div_array_asserts
    import div_pkg::*;
#(
    parameter int LANE_COUNT = div_pkg::LANE_COUNT
) (
    input logic                  clock,
    input logic                  reset,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_ack,
    input logic                  job_valid,
    input logic                  job_ready,
    input logic [LANE_COUNT-1:0] done_valid,
    input logic [LANE_COUNT-1:0] done_ready,
    input div_result_t           done_result [LANE_COUNT]
);

    ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("Wishbone ack seen outside an active bus cycle");

    // A divisor write that meets a full job queue gets no ack until its job is taken.
    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        (job_valid && !job_ready) |=> !wb_ack)
        else $error("A job was accepted while the job queue was full");

    for (genvar i = 0; i < LANE_COUNT; i++) begin : gen_lane_check
        result_stable: assert property (@(posedge clock) disable iff (reset)
            (done_valid[i] && !done_ready[i]) |=> $stable(done_result[i]))
            else $error("Lane %0d changed its result before the hand-off", i);
    end

endmodule

bind div_array_top div_array_asserts #(
    .LANE_COUNT (LANE_COUNT)
) asserts_i (
    .clock       (clock),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .job_valid   (job_valid),
    .job_ready   (job_ready),
    .done_valid  (lane_bus.done_valid),
    .done_ready  (lane_bus.done_ready),
    .done_result (lane_bus.done_result)
);

//--- test/div_array_tb.sv
`timescale 1ns/1ps

module div_array_tb
    import div_pkg::*;
();

    // Worst case per job for the slowest (single job) tests, plus reset and a margin.
    localparam int      JOB_TOTAL  = 7 + 21 + 40 + 300;
    localparam longint  TIMEOUT_NS = longint'(JOB_TOTAL) * (DATA_WIDTH + 40) * 8 + 2000;

    logic        clock;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    integer               seed = 32'h1cbd_de33;
    int                   errors;
    int                   checks;
    int                   max_wait;
    logic [TAG_WIDTH-1:0] tag_count;
    div_result_t          expected [256];
    bit                   pending [256];
    div_result_t          got_q [$];
    event                 got_ev;

    div_array_top div_array_top_i (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Integer division; a zero divisor gives all ones and keeps the dividend.
    function automatic div_result_t ref_divide(input div_job_t job);
        div_result_t r;
        r.tag = job.tag;
        if (job.divisor == '0) begin
            r.quotient  = '1;
            r.remainder = job.dividend;
        end else begin
            r.quotient  = job.dividend / job.divisor;
            r.remainder = job.dividend % job.divisor;
        end
        return r;
    endfunction

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic check_status(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %08h, expected %08h", what, got, exp);
        end
    endtask

    task automatic check_result(input div_result_t got);
        div_result_t exp;
        checks++;
        if (!pending[got.tag]) begin
            errors++;
            $display("Result with tag %0d came back but no such job was waiting", got.tag);
        end else begin
            pending[got.tag] = 1'b0;
            exp = expected[got.tag];
            if (got.quotient !== exp.quotient) begin
                errors++;
                $display("Mismatch quotient (tag %02h): got %08h, expected %08h",
                         got.tag, got.quotient, exp.quotient);
            end
            if (got.remainder !== exp.remainder) begin
                errors++;
                $display("Mismatch remainder (tag %02h): got %08h, expected %08h",
                         got.tag, got.remainder, exp.remainder);
            end
        end
    endtask

    // Counts falling edges until the ack is seen, so a stalled write shows up.
    task automatic wait_ack(output int waits);
        waits = 0;
        @(negedge clock);
        while (!wb_ack) begin
            waits++;
            @(negedge clock);
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data, output int waits);
        @(posedge clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack(waits);
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        int waits;
        @(posedge clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack(waits);
        data = wb_dat_r;
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic send_job(input logic [31:0] dividend, input logic [31:0] divisor,
                            input bit with_dividend);
        div_job_t job;
        int       waits;
        if (with_dividend) begin
            wb_write(ADDR_DIVIDEND, dividend, waits);
        end
        job.tag      = tag_count;
        job.dividend = dividend;
        job.divisor  = divisor;
        expected[tag_count] = ref_divide(job);
        pending[tag_count]  = 1'b1;
        tag_count = tag_count + TAG_WIDTH'(1);
        wb_write(ADDR_DIVISOR, divisor, waits);
        if (waits > max_wait) begin
            max_wait = waits;
        end
    endtask

    task automatic poll_result();
        logic [31:0] status;
        logic [31:0] word;
        div_result_t r;
        status = '0;
        while (!status[0]) begin
            wb_read(ADDR_STATUS, status);
        end
        wb_read(ADDR_TAG, word);
        r.tag = word[TAG_WIDTH-1:0];
        wb_read(ADDR_QUOTIENT, word);
        r.quotient = word;
        wb_read(ADDR_REMAINDER, word);
        r.remainder = word;
        got_q.push_back(r);
        -> got_ev;
    endtask

    task automatic single(input logic [31:0] dividend, input logic [31:0] divisor);
        send_job(dividend, divisor, 1'b1);
        poll_result();
    endtask

    task automatic burst(input int count, input bit shared_dividend);
        logic [31:0] dividend;
        logic [31:0] divisor;
        logic [4:0]  shift;
        dividend = rand_word();
        for (int i = 0; i < count; i++) begin
            if (!shared_dividend) begin
                dividend = rand_word();
            end
            shift   = 5'(rand_word());
            divisor = rand_word() >> shift;
            send_job(dividend, divisor, !shared_dividend || i == 0);
        end
    endtask

    task automatic drain(input int count);
        repeat (count) poll_result();
    endtask

    initial begin : compare
        div_result_t r;
        forever begin
            @(got_ev);
            while (got_q.size() > 0) begin
                r = got_q.pop_front();
                check_result(r);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        errors++;
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        finish_run();
    end

    initial begin : main
        logic [31:0] word;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        tag_count = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        wb_read(ADDR_STATUS, word);
        check_status("status after reset", word, 32'h0);
        wb_read(ADDR_REMAINDER, word);
        check_status("remainder with no result", word, 32'h0);
        wb_read(ADDR_STATUS, word);
        check_status("status after empty read", word, 32'h0);

        single(32'd144, 32'd12);
        single(32'd1000, 32'd7);
        single(32'd5, 32'd9);
        single(32'hdead_beef, 32'd1);
        single(32'hffff_ffff, 32'hffff_ffff);
        single(32'h1234_5678, 32'd0);
        single(32'd0, 32'd0);

        // Twenty jobs fill the lanes and both queues, so later divisor writes stall.
        max_wait = 0;
        burst(20, 1'b1);
        if (max_wait < 8) begin
            errors++;
            $display("Divisor writes were never held off by a full job queue");
        end
        wb_read(ADDR_STATUS, word);
        check_status("status with full queues", word, 32'h3);
        poll_result();
        send_job(rand_word(), rand_word(), 1'b1);
        drain(20);

        repeat (2) begin
            burst(20, 1'b0);
            drain(20);
        end
        // Enough jobs to carry the tag past 255.
        repeat (15) begin
            burst(20, 1'b0);
            drain(20);
        end

        repeat (2) @(posedge clock);
        for (int t = 0; t < 256; t++) begin
            if (pending[t]) begin
                errors++;
                $display("No result came back for tag %0d", t);
            end
        end
        finish_run();
    end

endmodule

//--- list.f
design/div_pkg.sv
design/lane_bus_if.sv
design/stream_fifo.sv
design/div_lane.sv
design/job_dispatcher.sv
design/result_collector.sv
design/wb_div_regs.sv
design/div_array_top.sv
test/div_array_asserts.sv
test/div_array_tb.sv

//--- run.sh
#!/bin/sh
# Builds the divider array testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module div_array_tb -f list.f -o div_array_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/div_array_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
